// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_lc4_core --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// ==== source/lc4_core.sv ====
`default_nettype none

module lc4_core import lc4_pkg::*; (
  input  wire           gwe,
  input  wire           i_rst_n,
  output wire word_t    o_imem_addr,
  input  wire word_t    i_imem_data,
  output wire word_t    o_dmem_addr,
  output wire word_t    o_dmem_wdata,
  output wire           o_dmem_we,
  input  wire word_t    i_dmem_rdata,
  output wire           o_rf_we,      // Register write trace
  output wire reg_sel_t o_rf_wsel,
  output wire word_t    o_rf_wdata
);

  lc4_wb_if wb ();

  word_t d_pc, d_insn, rs_data, rt_data, target;
  logic  d_valid, stall, redirect, load_nzp_we;
  nzp_t  load_nzp;
  ctrl_t d_ctrl, x_ctrl;
  dx_t   dx;
  xm_t   xm;
  fwd_e  fwd_a, fwd_b;

  lc4_fetch fetch_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall), .i_redirect(redirect),
    .i_target(target), .i_imem_data(i_imem_data), .o_pc(o_imem_addr),
    .o_d_valid(d_valid), .o_d_pc(d_pc), .o_d_insn(d_insn));

  lc4_decode decode_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_valid(d_valid), .i_pc(d_pc), .i_insn(d_insn),
    .i_stall(stall), .i_flush(redirect), .i_rs_data(rs_data), .i_rt_data(rt_data),
    .o_d_ctrl(d_ctrl), .o_dx(dx));

  lc4_regfile regfile_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt),
    .o_rs_data(rs_data), .o_rt_data(rt_data), .wb(wb.rf_sink));

  lc4_hazard hazard_i (
    .i_d_ctrl(d_ctrl), .i_x_ctrl(x_ctrl), .i_x_valid(dx.valid),
    .i_m_ctrl(xm.ctrl), .i_m_valid(xm.valid), .wb(wb.fwd_sink),
    .o_stall(stall), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b));

  lc4_execute execute_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_dx(dx), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
    .i_m_result(xm.result), .wb(wb.fwd_sink), .i_m_load_nzp_we(load_nzp_we),
    .i_m_load_nzp(load_nzp), .o_redirect(redirect), .o_target(target),
    .o_xm(xm), .o_x_ctrl(x_ctrl));

  lc4_memory memory_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_xm(xm), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata), .o_dmem_we(o_dmem_we),
    .o_load_nzp_we(load_nzp_we), .o_load_nzp(load_nzp), .wb(wb.wb_src));

  // Trace taps the writeback bus directly
  assign o_rf_we    = wb.wb_we;
  assign o_rf_wsel  = wb.wb_sel;
  assign o_rf_wdata = wb.wb_data;

endmodule

`default_nettype wire

// ==== source/lc4_decode.sv ====
`default_nettype none

`include "lc4_macros.svh"

module lc4_decode import lc4_pkg::*; (
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire        i_valid,
  input  wire word_t i_pc,
  input  wire word_t i_insn,
  input  wire        i_stall,
  input  wire        i_flush,
  input  wire word_t i_rs_data,
  input  wire word_t i_rt_data,
  output ctrl_t      o_d_ctrl,
  output dx_t        o_dx
);

  logic [3:0] opcode;
  alu_op_e    rr_op;    // ALU op of an ARITH/LOGIC word, PASS if unsupported
  ctrl_t      ctrl;
  word_t      imm;
  word_t      sext5, sext6, sext9, zext8;

  assign opcode = i_insn[15:12];
  assign sext5  = {{(`LC4_XLEN-5){i_insn[4]}}, i_insn[4:0]};
  assign sext6  = {{(`LC4_XLEN-6){i_insn[5]}}, i_insn[5:0]};
  assign sext9  = {{(`LC4_XLEN-9){i_insn[8]}}, i_insn[8:0]};
  assign zext8  = {{(`LC4_XLEN-8){1'b0}}, i_insn[7:0]};  // HICONST byte

  // opcode[2] splits LOGIC (0101) from ARITH (0001)
  always_comb begin
    if (i_insn[5]) begin
      rr_op = opcode[2] ? ALU_AND : ALU_ADD;  // imm5 forms
    end else begin
      case ({opcode[2], i_insn[4:3]})
        3'b000:  rr_op = ALU_ADD;
        3'b010:  rr_op = ALU_SUB;
        3'b100:  rr_op = ALU_AND;
        3'b110:  rr_op = ALU_OR;
        3'b111:  rr_op = ALU_XOR;
        default: rr_op = ALU_PASS;  // MUL, DIV, NOT run as NOP
      endcase
    end
  end

  always_comb begin
    ctrl        = '0;
    ctrl.rs     = i_insn[8:6];
    ctrl.rt     = i_insn[2:0];
    ctrl.rd     = i_insn[11:9];
    ctrl.alu_op = ALU_PASS;
    imm         = sext6;
    case (opcode)
      `LC4_OP_BR: begin
        ctrl.is_branch = 1'b1;
        ctrl.br_mask   = i_insn[11:9];
        ctrl.alu_op    = ALU_BRTGT;
        imm            = sext9;
      end
      `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
        imm = sext5;
        if (rr_op != ALU_PASS) begin
          ctrl.rs_re      = 1'b1;
          ctrl.rt_re      = !i_insn[5];  // Register form only
          ctrl.regfile_we = 1'b1;
          ctrl.nzp_we     = 1'b1;
          ctrl.alu_op     = rr_op;
        end
      end
      `LC4_OP_LDR: begin
        ctrl.rs_re      = 1'b1;
        ctrl.regfile_we = 1'b1;
        ctrl.nzp_we     = 1'b1;
        ctrl.is_load    = 1'b1;
        ctrl.alu_op     = ALU_ADD;  // Base + offset
      end
      `LC4_OP_STR: begin
        ctrl.rt         = i_insn[11:9];  // Store data lives in the rd field
        ctrl.rs_re      = 1'b1;
        ctrl.rt_re      = 1'b1;
        ctrl.is_store   = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      `LC4_OP_CONST: begin
        ctrl.regfile_we = 1'b1;
        ctrl.nzp_we     = 1'b1;
        ctrl.alu_op     = ALU_CONST;
        imm             = sext9;
      end
      `LC4_OP_HICONST: begin
        ctrl.rs         = i_insn[11:9];  // Reads its own rd, so MX covers CONST/HICONST
        ctrl.rs_re      = 1'b1;
        ctrl.regfile_we = 1'b1;
        ctrl.nzp_we     = 1'b1;
        ctrl.alu_op     = ALU_HICONST;
        imm             = zext8;
      end
      default: ;  // Anything else is a NOP
    endcase
    if (!i_valid) begin
      ctrl = '0;  // Empty slot requests nothing
    end
  end

  assign o_d_ctrl = ctrl;  // Selects also feed the regfile

  // Decode/execute register, bubble on stall or flush
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dx.valid <= 1'b0;
    end else begin
      o_dx.valid   <= i_valid && !i_stall && !i_flush;
      o_dx.pc      <= i_pc;
      o_dx.imm     <= imm;
      o_dx.ctrl    <= ctrl;
      o_dx.rs_data <= i_rs_data;
      o_dx.rt_data <= i_rt_data;
    end
  end

  // Unknown opcodes and the MUL, DIV and NOT forms change no state
  assert property (@(posedge gwe) disable iff (!i_rst_n)
    i_valid && (!(opcode inside {`LC4_OP_BR, `LC4_OP_ARITH, `LC4_OP_LOGIC, `LC4_OP_LDR,
                                 `LC4_OP_STR, `LC4_OP_CONST, `LC4_OP_HICONST}) ||
                (opcode inside {`LC4_OP_ARITH, `LC4_OP_LOGIC} && !i_insn[5] &&
                 {opcode[2], i_insn[4:3]} inside {3'b001, 3'b011, 3'b101}))
    |-> !(o_d_ctrl.regfile_we || o_d_ctrl.nzp_we || o_d_ctrl.is_store));

endmodule

`default_nettype wire

// ==== source/lc4_execute.sv ====
`default_nettype none

module lc4_execute import lc4_pkg::*; (
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire dx_t   i_dx,
  input  wire fwd_e  i_fwd_a,
  input  wire fwd_e  i_fwd_b,
  input  wire word_t i_m_result,
  lc4_wb_if.fwd_sink wb,
  input  wire        i_m_load_nzp_we,
  input  wire nzp_t  i_m_load_nzp,
  output logic       o_redirect,
  output word_t      o_target,
  output xm_t        o_xm,
  output ctrl_t      o_x_ctrl
);

  word_t a_op, rt_op, b_op, result;
  nzp_t  nzp_q;
  logic  alu_nzp_we;

  function automatic word_t bypass(input fwd_e sel, input word_t rf);
    case (sel)
      FWD_MX:  return i_m_result;
      FWD_WX:  return wb.wb_data;
      default: return rf;
    endcase
  endfunction

  always_comb begin
    a_op  = bypass(i_fwd_a, i_dx.rs_data);
    rt_op = bypass(i_fwd_b, i_dx.rt_data);
  end

  // STR reads rt for data, address still takes the offset
  assign b_op = (i_dx.ctrl.rt_re && !i_dx.ctrl.is_store) ? rt_op : i_dx.imm;

  always_comb begin
    case (i_dx.ctrl.alu_op)
      ALU_ADD:     result = a_op + b_op;
      ALU_SUB:     result = a_op - b_op;
      ALU_AND:     result = a_op & b_op;
      ALU_OR:      result = a_op | b_op;
      ALU_XOR:     result = a_op ^ b_op;
      ALU_CONST:   result = i_dx.imm;
      ALU_HICONST: result = {i_dx.imm[7:0], a_op[7:0]};
      ALU_BRTGT:   result = i_dx.pc + word_t'(1) + i_dx.imm;
      default:     result = a_op;
    endcase
  end

  assign alu_nzp_we = i_dx.valid && i_dx.ctrl.nzp_we && !i_dx.ctrl.is_load;

  // Loads land one cycle later from memory; the younger op wins a tie
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      nzp_q <= 3'b010;
    end else if (alu_nzp_we) begin
      nzp_q <= nzp_of(result);
    end else if (i_m_load_nzp_we) begin
      nzp_q <= i_m_load_nzp;
    end
  end

  assign o_redirect = i_dx.valid && i_dx.ctrl.is_branch && |(i_dx.ctrl.br_mask & nzp_q);
  assign o_target   = result;
  assign o_x_ctrl   = i_dx.ctrl;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_xm.valid <= 1'b0;
    end else begin
      o_xm.valid      <= i_dx.valid;
      o_xm.ctrl       <= i_dx.ctrl;
      o_xm.result     <= result;
      o_xm.store_data <= rt_op;  // Bypassed store data
    end
  end

  // Only a decoded BR may steer fetch, with its target from the branch adder
  assert property (@(posedge gwe) disable iff (!i_rst_n)
    o_redirect |-> i_dx.ctrl.alu_op == ALU_BRTGT && !i_dx.ctrl.regfile_we &&
                   !i_dx.ctrl.is_store);

  // The slot behind a taken branch is squashed
  assert property (@(posedge gwe) disable iff (!i_rst_n)
    o_redirect |=> !i_dx.valid);

  // A retiring NZP writer is still current unless the ALU op behind it already replaced it
  assert property (@(posedge gwe) disable iff (!i_rst_n)
    wb.wb_nzp_we && !(o_xm.valid && o_xm.ctrl.nzp_we && !o_xm.ctrl.is_load)
    |-> nzp_q == wb.wb_nzp);

endmodule

`default_nettype wire

// ==== source/lc4_fetch.sv ====
`default_nettype none

`include "lc4_macros.svh"

module lc4_fetch import lc4_pkg::*; (
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire        i_stall,
  input  wire        i_redirect,
  input  wire word_t i_target,
  input  wire word_t i_imem_data,
  output word_t      o_pc,
  output logic       o_d_valid,
  output word_t      o_d_pc,
  output word_t      o_d_insn
);

  word_t pc_q;
  word_t pc_plus1;

  assign pc_plus1 = pc_q + word_t'(1);  // Not-taken prediction
  assign o_pc     = pc_q;               // Doubles as imem address

  // PC and fetch/decode latch; redirect beats stall
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q      <= `LC4_RESET_PC;
      o_d_valid <= 1'b0;
    end else if (i_redirect) begin
      pc_q      <= i_target;
      o_d_valid <= 1'b0;       // Kill the wrong-path fetch
    end else if (!i_stall) begin
      pc_q      <= pc_plus1;
      o_d_valid <= 1'b1;
      o_d_pc    <= pc_q;
      o_d_insn  <= i_imem_data;
    end
  end

  // A load-use stall freezes the front end for exactly one cycle
  assert property (@(posedge gwe) disable iff (!i_rst_n)
    i_stall && !i_redirect |=> $stable(o_pc) && !i_stall);

endmodule

`default_nettype wire

// ==== source/lc4_hazard.sv ====
`default_nettype none

module lc4_hazard import lc4_pkg::*; (
  input  wire ctrl_t i_d_ctrl,
  input  wire ctrl_t i_x_ctrl,
  input  wire        i_x_valid,
  input  wire ctrl_t i_m_ctrl,
  input  wire        i_m_valid,
  lc4_wb_if.fwd_sink wb,
  output logic       o_stall,
  output fwd_e       o_fwd_a,
  output fwd_e       o_fwd_b
);

  logic x_load;  // Load in execute, data not ready until writeback
  logic m_alu;   // Memory stage holds an ALU result bound for a register

  assign x_load = i_x_valid && i_x_ctrl.is_load && i_x_ctrl.regfile_we;
  assign m_alu  = i_m_valid && i_m_ctrl.regfile_we && !i_m_ctrl.is_load;

  // Load-use, plus any branch behind a load (NZP comes late)
  assign o_stall = x_load && ((i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd) ||
                              (i_d_ctrl.rt_re && i_d_ctrl.rt == i_x_ctrl.rd) ||
                              i_d_ctrl.is_branch);

  // Nearest producer wins
  function automatic fwd_e pick(input reg_sel_t sel, input logic re);
    if (re && m_alu && i_m_ctrl.rd == sel) return FWD_MX;
    if (re && wb.wb_we && wb.wb_sel == sel) return FWD_WX;
    return FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_a = pick(i_x_ctrl.rs, i_x_ctrl.rs_re);
    o_fwd_b = pick(i_x_ctrl.rt, i_x_ctrl.rt_re);
  end

endmodule

`default_nettype wire

// ==== source/lc4_macros.svh ====
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// Datapath sizing
`define LC4_XLEN     16
`define LC4_NREGS    8
`define LC4_RESET_PC 16'h8200  // First fetch address out of reset

// Opcode field [15:12] of the supported subset
`define LC4_OP_BR      4'd0
`define LC4_OP_ARITH   4'd1   // ADD, SUB, ADD imm5
`define LC4_OP_LOGIC   4'd5   // AND, OR, XOR, AND imm5
`define LC4_OP_LDR     4'd6
`define LC4_OP_STR     4'd7
`define LC4_OP_CONST   4'd9
`define LC4_OP_HICONST 4'd13

`endif

// ==== source/lc4_memory.sv ====
`default_nettype none

module lc4_memory import lc4_pkg::*; (
  input  wire        gwe,
  input  wire        i_rst_n,
  input  wire xm_t   i_xm,
  input  wire word_t i_dmem_rdata,
  output word_t      o_dmem_addr,
  output word_t      o_dmem_wdata,
  output logic       o_dmem_we,
  output logic       o_load_nzp_we,
  output nzp_t       o_load_nzp,
  lc4_wb_if.wb_src   wb
);

  word_t wb_value;

  assign o_dmem_addr  = i_xm.result;                    // Address from execute
  assign o_dmem_wdata = i_xm.store_data;
  assign o_dmem_we    = i_xm.valid && i_xm.ctrl.is_store;  // Written at end of cycle

  // Load NZP goes back to the NZP register in execute
  assign o_load_nzp_we = i_xm.valid && i_xm.ctrl.is_load && i_xm.ctrl.nzp_we;
  assign o_load_nzp    = nzp_of(i_dmem_rdata);

  assign wb_value = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.result;

  // Memory/writeback register
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wb.wb_we     <= 1'b0;
      wb.wb_nzp_we <= 1'b0;
    end else begin
      wb.wb_we     <= i_xm.valid && i_xm.ctrl.regfile_we;
      wb.wb_nzp_we <= i_xm.valid && i_xm.ctrl.nzp_we;
      wb.wb_sel    <= i_xm.ctrl.rd;
      wb.wb_data   <= wb_value;
      wb.wb_nzp    <= nzp_of(wb_value);
    end
  end

endmodule

`default_nettype wire

// ==== source/lc4_pkg.sv ====
`default_nettype none

`include "lc4_macros.svh"

package lc4_pkg;

  typedef logic [`LC4_XLEN-1:0]          word_t;     // Data word or address
  typedef logic [$clog2(`LC4_NREGS)-1:0] reg_sel_t;  // Register index
  typedef logic [2:0]                    nzp_t;      // {N, Z, P}

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_CONST,    // Sign-extended imm9
    ALU_HICONST,  // New upper byte, low byte of rd kept
    ALU_BRTGT,    // PC + 1 + offset
    ALU_PASS      // NOP slot
  } alu_op_e;

  // Operand source for execute
  typedef enum logic [1:0] {FWD_NONE, FWD_MX, FWD_WX} fwd_e;

  typedef struct packed {
    reg_sel_t rs;
    reg_sel_t rt;
    reg_sel_t rd;
    logic     rs_re;
    logic     rt_re;
    logic     regfile_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    nzp_t     br_mask;     // Conditions that take the branch
    alu_op_e  alu_op;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t imm;      // Already extended
    ctrl_t ctrl;
    word_t rs_data;
    word_t rt_data;
  } dx_t;

  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t result;      // ALU result, or address for LDR/STR
    word_t store_data;
  } xm_t;

  // Condition code of a value being written back
  function automatic nzp_t nzp_of(input word_t w);
    if (w[`LC4_XLEN-1]) return 3'b100;
    if (w == '0)        return 3'b010;
    return 3'b001;
  endfunction

endpackage

`default_nettype wire

// ==== source/lc4_regfile.sv ====
`default_nettype none

`include "lc4_macros.svh"

module lc4_regfile import lc4_pkg::*; (
  input  wire           gwe,
  input  wire           i_rst_n,
  input  wire reg_sel_t i_rs,
  input  wire reg_sel_t i_rt,
  output word_t         o_rs_data,
  output word_t         o_rt_data,
  lc4_wb_if.rf_sink     wb
);

  word_t regs [`LC4_NREGS];

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `LC4_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wb_we) begin
      regs[wb.wb_sel] <= wb.wb_data;
    end
  end

  // Write-through so decode sees a value retiring this cycle
  function automatic word_t read_port(input reg_sel_t sel);
    return (wb.wb_we && wb.wb_sel == sel) ? wb.wb_data : regs[sel];
  endfunction

  always_comb begin
    o_rs_data = read_port(i_rs);
    o_rt_data = read_port(i_rt);
  end

endmodule

`default_nettype wire

// ==== source/lc4_wb_if.sv ====
`default_nettype none

interface lc4_wb_if import lc4_pkg::*; ();

  logic     wb_we;      // Qualified by valid already
  reg_sel_t wb_sel;
  word_t    wb_data;    // ALU result or loaded word
  logic     wb_nzp_we;
  nzp_t     wb_nzp;     // Condition code of wb_data

  modport wb_src   (output wb_we, wb_sel, wb_data, wb_nzp_we, wb_nzp);
  modport rf_sink  (input wb_we, wb_sel, wb_data);
  modport fwd_sink (input wb_we, wb_sel, wb_data, wb_nzp_we, wb_nzp);

endinterface

`default_nettype wire

// ==== src.f ====
+incdir+source
source/lc4_pkg.sv
source/lc4_wb_if.sv
source/lc4_fetch.sv
source/lc4_decode.sv
source/lc4_regfile.sv
source/lc4_hazard.sv
source/lc4_execute.sv
source/lc4_memory.sv
source/lc4_core.sv
test/tb_lc4_core.sv

// ==== test/tb_lc4_core.sv ====
`default_nettype none

`include "lc4_macros.svh"

module tb_lc4_core import lc4_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    HALF_PERIOD  = 4;           // 8 ns clock
  localparam int    RESET_CYCLES = 16;
  localparam int    PREFIX_LEN   = 18;          // Directed hazard sequence
  localparam int    RANDOM_LEN   = 200;
  localparam int    LOOP_COPIES  = 4;           // Any forward jump of 1 to 3 lands on one
  localparam int    DRAIN_CYCLES = 8;           // Longer than fetch to writeback plus a stall
  localparam int    MODEL_STEPS  = 4000;
  localparam word_t LOOP_WORD    = 16'h0FFF;    // BR nzp, -1

  logic     gwe        = 1'b0;
  logic     i_rst_n    = 1'b0;
  word_t    imem_data  = '0;
  word_t    dmem_rdata = '0;
  word_t    imem_addr, dmem_addr, dmem_wdata, rf_wdata;
  logic     dmem_we, rf_we;
  reg_sel_t rf_wsel;

  word_t imem [0:255];       // Program, based at the reset PC
  word_t dmem [0:65535];     // Memory seen by the DUT
  word_t m_dmem [0:65535];   // Model copy
  word_t m_regs [0:7];
  nzp_t  m_nzp;
  int    prog_len;

  // Expected trace from the model, in program order
  reg_sel_t exp_wsel[$];
  word_t    exp_wdata[$];
  word_t    exp_saddr[$];
  word_t    exp_sdata[$];

  int   n_wr     = 0;
  int   n_st     = 0;
  int   errors   = 0;
  int   cycles   = 0;
  int   drain    = 0;
  int   limit    = 0;
  logic finished = 1'b0;

  lc4_core lc4_core_i (
    .gwe(gwe), .i_rst_n(i_rst_n), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_we(dmem_we),
    .i_dmem_rdata(dmem_rdata), .o_rf_we(rf_we), .o_rf_wsel(rf_wsel),
    .o_rf_wdata(rf_wdata));

  always #HALF_PERIOD gwe = ~gwe;

  // Instruction encoders
  function automatic word_t rrr_word(input logic [3:0] op, input int rd, rs, sub, rt);
    return {op, rd[2:0], rs[2:0], 1'b0, sub[1:0], rt[2:0]};
  endfunction

  function automatic word_t imm5_word(input logic [3:0] op, input int rd, rs, imm);
    return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
  endfunction

  function automatic word_t mem_word(input logic [3:0] op, input int rd, rs, off);
    return {op, rd[2:0], rs[2:0], off[5:0]};  // rd field is the data reg for STR
  endfunction

  function automatic word_t const_word(input int rd, imm);
    return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
  endfunction

  function automatic word_t hiconst_word(input int rd, imm);
    return {`LC4_OP_HICONST, rd[2:0], 1'b1, imm[7:0]};
  endfunction

  function automatic word_t branch_word(input int mask, off);
    return {`LC4_OP_BR, mask[2:0], off[8:0]};
  endfunction

  function automatic word_t sign_extend(input word_t v, input int bits);
    word_t s;
    s = v << (16 - bits);
    return word_t'($signed(s) >>> (16 - bits));
  endfunction

  // Outside the program reads as BR with empty mask
  function automatic word_t fetch_word(input word_t addr);
    int idx;
    idx = int'(addr) - int'(`LC4_RESET_PC);
    if (idx >= 0 && idx < prog_len) return imem[idx];
    return 16'h0000;
  endfunction

  function automatic word_t random_insn();
    int rd, rs, rt, sub, kind;
    rd   = $urandom_range(7);
    rs   = $urandom_range(7);
    rt   = $urandom_range(7);
    sub  = $urandom_range(2);      // AND, OR, XOR
    sub  = (sub != 0) ? sub + 1 : 0;
    kind = $urandom_range(9);
    case (kind)
      0: return branch_word($urandom_range(7), $urandom_range(3, 1));  // Forward only
      1: return rrr_word(`LC4_OP_ARITH, rd, rs, ($urandom_range(1) == 1) ? 2 : 0, rt);
      2: return imm5_word(`LC4_OP_ARITH, rd, rs, $urandom_range(31));
      3: return rrr_word(`LC4_OP_LOGIC, rd, rs, sub, rt);
      4: return imm5_word(`LC4_OP_LOGIC, rd, rs, $urandom_range(31));
      5: return mem_word(`LC4_OP_LDR, rd, rs, $urandom_range(63));
      6: return mem_word(`LC4_OP_STR, rd, rs, $urandom_range(63));
      7: return const_word(rd, $urandom_range(511));
      8: return hiconst_word(rd, $urandom_range(255));
      default: return rrr_word(`LC4_OP_ARITH, rd, rs, 0, rt);
    endcase
  endfunction

  task automatic build_program();
    for (int i = 0; i < 256; i++) imem[i] = '0;
    imem[0]  = const_word(1, 5);
    imem[1]  = const_word(2, 'h1FD);                  // -3
    imem[2]  = rrr_word(`LC4_OP_ARITH, 3, 1, 0, 2);   // r1 via WX, r2 via MX
    imem[3]  = rrr_word(`LC4_OP_ARITH, 4, 3, 2, 1);   // SUB on MX result
    imem[4]  = const_word(5, 'h034);
    imem[5]  = hiconst_word(5, 'h12);                 // CONST/HICONST pair
    imem[6]  = mem_word(`LC4_OP_STR, 5, 3, 4);        // Store 0x1234 at 6
    imem[7]  = mem_word(`LC4_OP_LDR, 6, 3, 4);        // Read it back
    imem[8]  = rrr_word(`LC4_OP_ARITH, 7, 6, 0, 6);   // Load-use stall
    imem[9]  = mem_word(`LC4_OP_LDR, 0, 4, 0);        // Fill word at 0xFFFD is negative
    imem[10] = branch_word(3'b100, 1);                // Taken on load NZP
    imem[11] = const_word(1, 'h063);                  // Skipped
    imem[12] = branch_word(3'b011, 2);                // Not taken
    imem[13] = rrr_word(`LC4_OP_LOGIC, 2, 1, 3, 5);   // XOR
    imem[14] = rrr_word(`LC4_OP_LOGIC, 3, 2, 2, 0);
    imem[15] = imm5_word(`LC4_OP_LOGIC, 4, 3, 'h07);
    imem[16] = imm5_word(`LC4_OP_ARITH, 4, 4, 'h1F);  // ADD -1 back to back
    imem[17] = mem_word(`LC4_OP_STR, 4, 5, 'h3E);     // Store data from MX
    for (int i = 0; i < RANDOM_LEN; i++) imem[PREFIX_LEN + i] = random_insn();
    for (int i = 0; i < LOOP_COPIES; i++) imem[PREFIX_LEN + RANDOM_LEN + i] = LOOP_WORD;
    prog_len = PREFIX_LEN + RANDOM_LEN + LOOP_COPIES;
  endtask

  task automatic retire_write(input reg_sel_t sel, input word_t val);
    m_regs[sel] = val;
    m_nzp = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
    exp_wsel.push_back(sel);
    exp_wdata.push_back(val);
  endtask

  // Instruction-set model, one instruction per step
  task automatic run_model();
    word_t      pc, pc_next, insn, b, addr;
    logic [2:0] rd, rs;
    int         steps;
    for (int i = 0; i < 8; i++) m_regs[i] = '0;
    m_nzp = 3'b010;
    pc    = `LC4_RESET_PC;
    steps = 0;
    insn  = fetch_word(pc);
    while (insn != LOOP_WORD && steps < MODEL_STEPS) begin
      rd      = insn[11:9];
      rs      = insn[8:6];
      b       = insn[5] ? sign_extend(insn, 5) : m_regs[insn[2:0]];
      pc_next = pc + 16'd1;
      case (insn[15:12])
        `LC4_OP_BR:
          if ((insn[11:9] & m_nzp) != 3'b000) pc_next = pc + 16'd1 + sign_extend(insn, 9);
        `LC4_OP_ARITH:
          if (insn[5] || insn[4:3] == 2'b00) retire_write(rd, m_regs[rs] + b);
          else if (insn[4:3] == 2'b10) retire_write(rd, m_regs[rs] - b);
        `LC4_OP_LOGIC:
          if (insn[5] || insn[4:3] == 2'b00) retire_write(rd, m_regs[rs] & b);
          else if (insn[4:3] == 2'b10) retire_write(rd, m_regs[rs] | b);
          else if (insn[4:3] == 2'b11) retire_write(rd, m_regs[rs] ^ b);
        `LC4_OP_LDR: begin
          addr = m_regs[rs] + sign_extend(insn, 6);
          retire_write(rd, m_dmem[addr]);
        end
        `LC4_OP_STR: begin
          addr = m_regs[rs] + sign_extend(insn, 6);
          m_dmem[addr] = m_regs[rd];
          exp_saddr.push_back(addr);
          exp_sdata.push_back(m_regs[rd]);
        end
        `LC4_OP_CONST:   retire_write(rd, sign_extend(insn, 9));
        `LC4_OP_HICONST: retire_write(rd, {insn[7:0], m_regs[rd][7:0]});
        default: ;
      endcase
      pc    = pc_next;
      insn  = fetch_word(pc);
      steps++;
    end
  endtask

  task automatic match_write();
    assert (n_wr < exp_wsel.size()) else begin
      errors++;
      $display("Extra register write to r%0d after all %0d model writes", rf_wsel, n_wr);
    end
    if (n_wr < exp_wsel.size()) begin
      assert (rf_wsel == exp_wsel[n_wr] && rf_wdata == exp_wdata[n_wr]) else begin
        errors++;
        $display("[ERROR] reg_write #%0d: expected r%0d=%h actual r%0d=%h",
                 n_wr, exp_wsel[n_wr], exp_wdata[n_wr], rf_wsel, rf_wdata);
      end
    end
    n_wr++;
  endtask

  task automatic verify_store();
    assert (n_st < exp_saddr.size()) else begin
      errors++;
      $display("Extra store to %h after all %0d model stores", dmem_addr, n_st);
    end
    if (n_st < exp_saddr.size()) begin
      assert (dmem_addr == exp_saddr[n_st] && dmem_wdata == exp_sdata[n_st]) else begin
        errors++;
        $display("[ERROR] store #%0d: expected [%h]=%h actual [%h]=%h",
                 n_st, exp_saddr[n_st], exp_sdata[n_st], dmem_addr, dmem_wdata);
      end
    end
    dmem[dmem_addr] = dmem_wdata;  // Store lands before the next read
    n_st++;
  endtask

  // Checks, reset release and memory reads, all on the falling edge
  always @(negedge gwe) begin
    cycles++;
    if (!i_rst_n) begin
      assert (!rf_we && !dmem_we) else begin
        errors++;
        $display("Write enable raised during reset at cycle %0d", cycles);
      end
      assert (imem_addr == `LC4_RESET_PC) else begin
        errors++;
        $display("[ERROR] reset_pc: expected %h actual %h", `LC4_RESET_PC, imem_addr);
      end
      if (cycles == RESET_CYCLES) i_rst_n = 1'b1;
    end else begin
      if (rf_we) match_write();
      if (dmem_we) verify_store();
      if (drain > 0 || fetch_word(imem_addr) == LOOP_WORD) begin
        drain++;  // Older instructions still retire behind the loop fetch
      end
      if (drain == DRAIN_CYCLES) finished = 1'b1;
    end
    imem_data  = fetch_word(imem_addr);
    dmem_rdata = dmem[dmem_addr];
    if (cycles >= limit && !finished) begin
      $display("Timeout after %0d cycles before the DUT reached the final loop", cycles);
      $display("Errors %0d, writes %0d of %0d, stores %0d of %0d",
               errors, n_wr, exp_wsel.size(), n_st, exp_saddr.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(32'he672);
    for (int a = 0; a < 65536; a++) begin
      dmem[a]   = word_t'(a) ^ 16'h5A5A;  // Fill follows the full address
      m_dmem[a] = word_t'(a) ^ 16'h5A5A;
    end
    build_program();
    run_model();
    limit = RESET_CYCLES + 4 * prog_len + 64;
    $display("Program %0d words, model made %0d writes and %0d stores",
             prog_len, exp_wsel.size(), exp_saddr.size());
    wait (finished);
    assert (n_wr == exp_wsel.size() && n_st == exp_saddr.size()) else begin
      errors++;
      $display("DUT trace length differs from the model at the final loop");
    end
    $display("Errors %0d, writes %0d of %0d, stores %0d of %0d",
             errors, n_wr, exp_wsel.size(), n_st, exp_saddr.size());
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
